// ==== eth_measurer.f ====
eth_measurer_pkg.sv
eth_measurer_coord.sv
eth_ping_tx.sv
eth_ping_rx.sv
eth_measurer.sv
eth_measurer_assertions.sv
eth_measurer_tb.sv

// ==== eth_measurer.sv ====
// Round-trip latency measurer top. main_tx must loop to loop_rx and
// loop_tx back to main_rx outside the design.
// Streams have no back-pressure.
module eth_measurer (
	input logic clk,
	input logic rst,
	input logic enable,

	input eth_measurer_pkg::psize_t psize_req,
	input eth_measurer_pkg::cycles_t delay_time,
	input eth_measurer_pkg::cycles_t timeout,

	output eth_measurer_pkg::eth_stream_t main_tx,
	output eth_measurer_pkg::eth_stream_t loop_tx,
	input eth_measurer_pkg::eth_stream_t main_rx,
	input eth_measurer_pkg::eth_stream_t loop_rx,

	output logic done,
	output eth_measurer_pkg::meas_stats_t stats
);
	import eth_measurer_pkg::*;

	psize_t psize;
	ping_id_t ping_id;
	ping_id_t main_rx_ping_id;
	ping_id_t loop_rx_ping_id;
	logic main_tx_trigger;
	logic loop_tx_trigger;
	logic main_tx_begin;
	logic loop_tx_begin;

	eth_measurer_coord i_coord (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.psize_req(psize_req),
		.delay_time(delay_time),
		.timeout(timeout),
		.psize(psize),
		.ping_id(ping_id),
		.main_rx_ping_id(main_rx_ping_id),
		.loop_rx_ping_id(loop_rx_ping_id),
		.main_tx_trigger(main_tx_trigger),
		.loop_tx_trigger(loop_tx_trigger),
		.main_tx_begin(main_tx_begin),
		.loop_tx_begin(loop_tx_begin),
		.done(done),
		.stats(stats)
	);

	// Pings leave on main, pongs on loop
	eth_ping_tx #(.KIND(KIND_PING)) i_main_tx (
		.clk(clk),
		.rst(rst),
		.trigger(main_tx_trigger),
		.psize(psize),
		.ping_id(ping_id),
		.tx_begin(main_tx_begin),
		.tx(main_tx)
	);

	eth_ping_tx #(.KIND(KIND_PONG)) i_loop_tx (
		.clk(clk),
		.rst(rst),
		.trigger(loop_tx_trigger),
		.psize(psize),
		.ping_id(ping_id),
		.tx_begin(loop_tx_begin),
		.tx(loop_tx)
	);

	eth_ping_rx #(.KIND(KIND_PONG)) i_main_rx (
		.clk(clk),
		.rst(rst),
		.rx(main_rx),
		.rx_ping_id(main_rx_ping_id)
	);

	eth_ping_rx #(.KIND(KIND_PING)) i_loop_rx (
		.clk(clk),
		.rst(rst),
		.rx(loop_rx),
		.rx_ping_id(loop_rx_ping_id)
	);

endmodule

// ==== eth_measurer_assertions.sv ====
// Concurrent checks on the measurer's internal handshakes.
// Frame length is checked against the coordinator's psize, held for a whole exchange.
module eth_measurer_assertions (
	input logic clk,
	input logic rst,
	input logic main_tx_trigger,
	input logic loop_tx_trigger,
	input logic done,
	input eth_measurer_pkg::psize_t psize,
	input eth_measurer_pkg::eth_stream_t main_tx,
	input eth_measurer_pkg::eth_stream_t loop_tx
);
	timeunit 1ns;
	timeprecision 1ns;
	import eth_measurer_pkg::*;

	psize_t main_cnt; // Bytes sent so far in the current frame
	psize_t loop_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			main_cnt <= '0;
			loop_cnt <= '0;
		end else begin
			if (main_tx.valid) main_cnt <= main_tx.last ? '0 : main_cnt + psize_t'(1);
			if (loop_tx.valid) loop_cnt <= loop_tx.last ? '0 : loop_cnt + psize_t'(1);
		end
	end

	assert property (@(posedge clk) disable iff (rst) main_tx_trigger |-> !main_tx.valid)
		else $error("main generator triggered while sending");
	assert property (@(posedge clk) disable iff (rst) loop_tx_trigger |-> !loop_tx.valid)
		else $error("loop generator triggered while sending");
	assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done held longer than one cycle");
	assert property (@(posedge clk) disable iff (rst)
		main_tx.valid |-> (main_tx.last == (main_cnt == psize - psize_t'(1))))
		else $error("main_tx frame length differs from psize");
	assert property (@(posedge clk) disable iff (rst)
		loop_tx.valid |-> (loop_tx.last == (loop_cnt == psize - psize_t'(1))))
		else $error("loop_tx frame length differs from psize");

endmodule

bind eth_measurer eth_measurer_assertions i_assertions (.*);

// ==== eth_measurer_coord.sv ====
// Ping/pong coordinator with one exchange in flight at a time.
// Triggers go only to idle generators. Times are in clock cycles.
// delay_time or timeout of zero means no wait at all.
module eth_measurer_coord (
	input logic clk,
	input logic rst,
	input logic enable,

	input eth_measurer_pkg::psize_t psize_req,
	input eth_measurer_pkg::cycles_t delay_time,
	input eth_measurer_pkg::cycles_t timeout,

	output eth_measurer_pkg::psize_t psize,

	output eth_measurer_pkg::ping_id_t ping_id,
	input eth_measurer_pkg::ping_id_t main_rx_ping_id,
	input eth_measurer_pkg::ping_id_t loop_rx_ping_id,

	output logic main_tx_trigger,
	output logic loop_tx_trigger,
	input logic main_tx_begin,
	input logic loop_tx_begin,

	output logic done,
	output eth_measurer_pkg::meas_stats_t stats
);
	import eth_measurer_pkg::*;

	typedef enum logic [2:0] {
		ST_DELAY,
		ST_WAIT_PING_TX,
		ST_PING,
		ST_WAIT_PONG_TX,
		ST_PONG
	} state_t;

	state_t state, state_next;

	logic done_next;
	psize_t psize_q, psize_next; // Frame length of the exchange in flight
	ping_id_t ping_id_next;
	cycles_t count, count_next;
	cycles_t ping_time, ping_time_next; // Ping leg, held until done
	meas_stats_t stats_next;

	logic delay_over;
	logic timed_out;

	assign delay_over = (delay_time == '0) || (count >= delay_time - cycles_t'(1));
	assign timed_out = (timeout == '0) || (count >= timeout - cycles_t'(1));

	// Generators latch psize in the trigger cycle itself
	assign psize = main_tx_trigger ? psize_req : psize_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_DELAY;
			ping_id <= '0;
			done <= 1'b0;
			count <= '0;
			psize_q <= PSIZE_RESET;
			ping_time <= '0;
			stats <= '0;
		end else begin
			state <= state_next;
			ping_id <= ping_id_next;
			done <= done_next;
			count <= count_next;
			psize_q <= psize_next;
			ping_time <= ping_time_next;
			stats <= stats_next;
		end
	end

	always_comb begin
		state_next = state;
		ping_id_next = ping_id;
		done_next = 1'b0;
		count_next = count + cycles_t'(1);
		psize_next = psize_q;
		ping_time_next = ping_time;
		stats_next = stats;

		main_tx_trigger = 1'b0;
		loop_tx_trigger = 1'b0;

		case (state)
			ST_DELAY: begin
				if (!enable) begin
					count_next = '0; // Delay restarts while disabled
				end else if (delay_over) begin
					state_next = ST_WAIT_PING_TX;
					count_next = '0;
					psize_next = psize_req;
					main_tx_trigger = 1'b1;
				end
			end

			ST_WAIT_PING_TX: begin
				if (main_tx_begin) begin
					state_next = ST_PING;
					count_next = cycles_t'(1);
				end
			end

			ST_PING: begin
				if (loop_rx_ping_id == ping_id) begin
					// Ping seen on loop port, answer with pong
					state_next = ST_WAIT_PONG_TX;
					count_next = '0;
					ping_time_next = count + cycles_t'(1);
					loop_tx_trigger = 1'b1;
				end else if (timed_out) begin
					state_next = ST_DELAY;
					count_next = '0;
					done_next = 1'b1;
					stats_next.ping_time = '1;
					stats_next.pong_time = '1;
					stats_next.pings_lost = stats.pings_lost + stat_t'(1);
				end
			end

			ST_WAIT_PONG_TX: begin
				if (loop_tx_begin) begin
					state_next = ST_PONG;
					count_next = cycles_t'(1);
				end
			end

			ST_PONG: begin
				if (main_rx_ping_id == ping_id) begin
					state_next = ST_DELAY;
					count_next = '0;
					done_next = 1'b1;
					ping_id_next = ping_id + ping_id_t'(1);
					stats_next.ping_time = ping_time;
					stats_next.pong_time = count + cycles_t'(1);
					stats_next.ping_pongs_good = stats.ping_pongs_good + stat_t'(1);
				end else if (timed_out) begin
					// Pong lost, ping leg still valid
					state_next = ST_DELAY;
					count_next = '0;
					done_next = 1'b1;
					ping_id_next = ping_id + ping_id_t'(1);
					stats_next.ping_time = ping_time;
					stats_next.pong_time = '1;
					stats_next.pongs_lost = stats.pongs_lost + stat_t'(1);
				end
			end

			default: begin
				state_next = ST_DELAY;
			end
		endcase
	end

endmodule

// ==== eth_measurer_pkg.sv ====
// Shared types and frame constants for the latency measurer.
// A frame is ethertype (2), kind (1), id (8, MSB first), then zero padding.
// No preamble, MAC addresses or FCS.
package eth_measurer_pkg;

	typedef logic [7:0] eth_byte_t;
	typedef logic [63:0] ping_id_t;
	typedef logic [31:0] cycles_t;
	typedef logic [15:0] psize_t;
	typedef logic [63:0] stat_t;

	// One byte beat, no back-pressure
	typedef struct packed {
		logic valid;
		logic last;
		eth_byte_t data;
	} eth_stream_t;

	typedef struct packed {
		cycles_t ping_time;
		cycles_t pong_time;
		stat_t ping_pongs_good;
		stat_t pings_lost;
		stat_t pongs_lost;
	} meas_stats_t;

	typedef enum logic [7:0] {
		KIND_PING = 8'h01,
		KIND_PONG = 8'h02
	} frame_kind_t;

	localparam logic [15:0] ETHERTYPE_MEAS = 16'h88B5;

	localparam psize_t PSIZE_RESET = 16'd46;
	localparam psize_t PSIZE_MIN = 16'd11; // Header plus id, no padding

	// Byte index of the first id byte
	localparam psize_t ID_FIRST = 16'd3;

endpackage

// ==== eth_measurer_tb.sv ====
// Testbench for the latency measurer. The cable is modelled as two fixed
// LOOP_D stage delay lines that can drop or corrupt the frames of one exchange.
// One exchange runs at a time. enable is pulsed per exchange so new settings apply.
module eth_measurer_tb;
	timeunit 1ns;
	timeprecision 1ns;
	import eth_measurer_pkg::*;

	localparam int LOOP_D = 3;
	localparam int RST_CYCLES = 16;
	localparam int IDLE_WINDOW = 300;
	localparam int N_RANDOM = 8;
	localparam int N_EXCH = N_RANDOM + 5;
	localparam int TIMEOUT = 200; // Above the longest leg of 64 + LOOP_D + 1
	localparam int PSIZE_MAX = 64;
	localparam int DELAY_MAX = 20;
	localparam int EXCH_MAX = DELAY_MAX + 2 * (PSIZE_MAX + LOOP_D + 2) + 1 + TIMEOUT + 4;
	localparam int CYCLE_LIMIT = RST_CYCLES + IDLE_WINDOW + N_EXCH * EXCH_MAX + 500;

	typedef enum {MODE_GOOD, MODE_DROP_PING, MODE_DROP_PONG, MODE_CORRUPT_PING} xchg_mode_t;

	logic clk;
	logic rst;
	logic enable;
	psize_t psize_req;
	cycles_t delay_time;
	cycles_t timeout;
	eth_stream_t main_tx;
	eth_stream_t loop_tx;
	eth_stream_t main_rx;
	eth_stream_t loop_rx;
	logic done;
	meas_stats_t stats;

	eth_stream_t [LOOP_D-1:0] ping_line = '0;
	eth_stream_t [LOOP_D-1:0] pong_line = '0;
	eth_stream_t ping_beat;
	eth_stream_t pong_beat;
	logic drop_ping;
	logic drop_pong;
	logic corrupt_ping;
	logic main_first; // Next main_tx byte starts a frame

	meas_stats_t exp_stats;
	meas_stats_t exp_now;
	meas_stats_t expect_q[$];
	ping_id_t frame_id;
	int frame_psize;
	int main_idx;
	int loop_idx;
	int errors;
	int tests;
	int tests_failed;
	int cycle_count;
	logic [31:0] rng;

	eth_measurer i_eth_measurer (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.psize_req(psize_req),
		.delay_time(delay_time),
		.timeout(timeout),
		.main_tx(main_tx),
		.loop_tx(loop_tx),
		.main_rx(main_rx),
		.loop_rx(loop_rx),
		.done(done),
		.stats(stats)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign loop_rx = ping_line[LOOP_D-1];
	assign main_rx = pong_line[LOOP_D-1];

	always @(posedge clk) begin
		ping_beat = drop_ping ? eth_stream_t'(0) : main_tx;
		if (corrupt_ping && main_first) begin
			ping_beat.data = ping_beat.data ^ 8'hFF; // Ethertype high byte
		end
		pong_beat = drop_pong ? eth_stream_t'(0) : loop_tx;
		ping_line <= {ping_line[LOOP_D-2:0], ping_beat};
		pong_line <= {pong_line[LOOP_D-2:0], pong_beat};
		if (main_tx.valid) begin
			main_first <= main_tx.last;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Stats after one exchange, from the leg timing psize + LOOP_D + 1
	function automatic meas_stats_t predict_stats(input meas_stats_t prev, input int psize,
			input xchg_mode_t mode);
		meas_stats_t s;
		cycles_t leg;
		s = prev;
		leg = cycles_t'(psize + LOOP_D + 1);
		case (mode)
			MODE_GOOD: begin
				s.ping_time = leg;
				s.pong_time = leg;
				s.ping_pongs_good = prev.ping_pongs_good + 1;
			end
			MODE_DROP_PONG: begin
				s.ping_time = leg;
				s.pong_time = '1;
				s.pongs_lost = prev.pongs_lost + 1;
			end
			default: begin
				s.ping_time = '1;
				s.pong_time = '1;
				s.pings_lost = prev.pings_lost + 1;
			end
		endcase
		return s;
	endfunction

	function automatic eth_byte_t expected_byte(input frame_kind_t kind, input int idx);
		if (idx == 0) return ETHERTYPE_MEAS[15:8];
		if (idx == 1) return ETHERTYPE_MEAS[7:0];
		if (idx == 2) return kind;
		if (idx < int'(PSIZE_MIN)) return frame_id[8 * (10 - idx) +: 8]; // Id, MSB first
		return 8'h00;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_beat(input string name, input frame_kind_t kind, input int idx,
			input eth_stream_t beat);
		if (beat.data !== expected_byte(kind, idx)) begin
			errors++;
			$display("MISMATCH %s.data byte %0d: got %h expected %h", name, idx, beat.data,
				expected_byte(kind, idx));
		end
		if (beat.last !== (idx == frame_psize - 1)) begin
			errors++;
			$display("MISMATCH %s.last byte %0d: got %h expected %h", name, idx, beat.last,
				idx == frame_psize - 1);
		end
	endtask

	always @(posedge clk) begin
		if (!rst && main_tx.valid) begin
			check_beat("main_tx", KIND_PING, main_idx, main_tx);
			main_idx <= main_tx.last ? 0 : main_idx + 1;
		end
		if (!rst && loop_tx.valid) begin
			check_beat("loop_tx", KIND_PONG, loop_idx, loop_tx);
			loop_idx <= loop_tx.last ? 0 : loop_idx + 1;
		end
	end

	always @(posedge clk) begin
		if (!rst && done) begin
			if (expect_q.size() == 0) begin
				errors++;
				$display("done strobe arrived with no exchange pending");
			end else begin
				exp_now = expect_q.pop_front();
				check_value("stats.ping_time", stats.ping_time, exp_now.ping_time);
				check_value("stats.pong_time", stats.pong_time, exp_now.pong_time);
				check_value("stats.ping_pongs_good", stats.ping_pongs_good,
					exp_now.ping_pongs_good);
				check_value("stats.pings_lost", stats.pings_lost, exp_now.pings_lost);
				check_value("stats.pongs_lost", stats.pongs_lost, exp_now.pongs_lost);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors != errs_before) begin
			tests_failed++;
		end
		$display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "failed");
	endtask

	task automatic check_idle(input int n);
		int errs_before;
		errs_before = errors;
		repeat (n) begin
			@(posedge clk);
			if (main_tx.valid || loop_tx.valid) begin
				errors++;
				$display("A frame was sent while enable was low");
			end
		end
		report_test("enable low", errs_before);
	endtask

	task automatic run_exchange(input xchg_mode_t mode, input int psize, input int delay);
		int errs_before;
		int waited;
		int start_exp;
		errs_before = errors;
		frame_id = exp_stats.ping_pongs_good + exp_stats.pongs_lost;
		frame_psize = psize;
		exp_stats = predict_stats(exp_stats, psize, mode);
		expect_q.push_back(exp_stats);
		start_exp = ((delay == 0) ? 1 : delay) + 1; // Edges from enable to byte 0 sampled
		@(posedge clk);
		psize_req <= psize_t'(psize);
		delay_time <= cycles_t'(delay);
		drop_ping <= (mode == MODE_DROP_PING);
		drop_pong <= (mode == MODE_DROP_PONG);
		corrupt_ping <= (mode == MODE_CORRUPT_PING);
		enable <= 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!main_tx.valid);
		enable <= 1'b0;
		if (waited != start_exp) begin
			errors++;
			$display("MISMATCH main_tx start delay: got %h expected %h", waited, start_exp);
		end
		do @(posedge clk); while (!done);
		@(posedge clk);
		report_test($sformatf("%s psize %0d delay %0d", mode.name(), psize, delay), errs_before);
	endtask

	initial begin
		int p;
		int d;
		rst = 1'b1;
		enable = 1'b0;
		psize_req = PSIZE_RESET;
		delay_time = '0;
		timeout = cycles_t'(TIMEOUT);
		drop_ping = 1'b0;
		drop_pong = 1'b0;
		corrupt_ping = 1'b0;
		main_first = 1'b1;
		main_idx = 0;
		loop_idx = 0;
		errors = 0;
		tests = 0;
		tests_failed = 0;
		cycle_count = 0;
		exp_stats = '0;
		frame_id = '0;
		frame_psize = PSIZE_RESET;
		rng = 32'd47;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		check_idle(IDLE_WINDOW);
		for (int i = 0; i < N_RANDOM; i++) begin
			rng = xorshift(rng);
			p = int'(PSIZE_MIN) + int'(rng % (PSIZE_MAX - int'(PSIZE_MIN) + 1));
			rng = xorshift(rng);
			d = int'(rng % (DELAY_MAX + 1));
			run_exchange(MODE_GOOD, p, d);
		end
		run_exchange(MODE_DROP_PING, 20, 3);
		run_exchange(MODE_GOOD, 20, 2); // Same id again
		run_exchange(MODE_DROP_PONG, 33, 0);
		run_exchange(MODE_CORRUPT_PING, int'(PSIZE_MIN), 7);
		run_exchange(MODE_GOOD, PSIZE_MAX, 0);
		if (expect_q.size() != 0) begin
			errors++;
			$display("%0d exchanges ended without a done strobe", expect_q.size());
		end
		$display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== eth_ping_rx.sv ====
// Parses a byte stream and keeps the id of the last good frame of kind KIND.
// Bad ethertype, other kind or a frame shorter than PSIZE_MIN is ignored.
// rx_ping_id resets to all ones, so it never matches id 0.
module eth_ping_rx #(
	parameter eth_measurer_pkg::frame_kind_t KIND = eth_measurer_pkg::KIND_PING
) (
	input logic clk,
	input logic rst,
	input eth_measurer_pkg::eth_stream_t rx,
	output eth_measurer_pkg::ping_id_t rx_ping_id
);
	import eth_measurer_pkg::*;

	psize_t cnt; // Bytes seen so far in this frame
	logic hdr_ok;
	ping_id_t id_sr;
	ping_id_t id_cur;
	logic in_id;
	logic frame_ok;

	assign in_id = (cnt >= ID_FIRST) && (cnt < PSIZE_MIN);
	assign id_cur = in_id ? {id_sr[55:0], rx.data} : id_sr; // Includes current byte
	assign frame_ok = hdr_ok && (cnt >= PSIZE_MIN - psize_t'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			hdr_ok <= 1'b0;
			rx_ping_id <= '1;
		end else if (rx.valid) begin
			if (rx.last) begin
				cnt <= '0;
				if (frame_ok) begin
					rx_ping_id <= id_cur;
				end
			end else if (cnt != '1) begin
				cnt <= cnt + psize_t'(1); // Saturates on very long frames
			end

			case (cnt)
				16'd0: hdr_ok <= (rx.data == ETHERTYPE_MEAS[15:8]);
				16'd1: hdr_ok <= hdr_ok && (rx.data == ETHERTYPE_MEAS[7:0]);
				16'd2: hdr_ok <= hdr_ok && (rx.data == KIND);
				default: hdr_ok <= hdr_ok;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx.valid && in_id) begin
			id_sr <= id_cur;
		end
	end

endmodule

// ==== eth_ping_tx.sv ====
// Sends one frame of psize bytes per trigger, one byte per cycle.
// Triggers while sending are ignored. psize must be nonzero.
// psize below PSIZE_MIN gives a truncated frame that parsers reject.
module eth_ping_tx #(
	parameter eth_measurer_pkg::frame_kind_t KIND = eth_measurer_pkg::KIND_PING
) (
	input logic clk,
	input logic rst,
	input logic trigger,
	input eth_measurer_pkg::psize_t psize,
	input eth_measurer_pkg::ping_id_t ping_id,
	output logic tx_begin,
	output eth_measurer_pkg::eth_stream_t tx
);
	import eth_measurer_pkg::*;

	typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

	tx_state_t state;
	psize_t cnt; // Byte index within frame
	psize_t len;
	ping_id_t id_sr;
	logic last_byte;
	logic in_id;

	assign last_byte = (cnt == len - psize_t'(1));
	assign in_id = (cnt >= ID_FIRST) && (cnt < PSIZE_MIN);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					cnt <= '0;
					if (trigger) begin
						state <= TX_SEND;
					end
				end
				TX_SEND: begin
					cnt <= cnt + psize_t'(1);
					if (last_byte) begin
						state <= TX_IDLE;
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// Id goes out MSB first from the top of the shift register
	always_ff @(posedge clk) begin
		if (state == TX_IDLE && trigger) begin
			len <= psize;
			id_sr <= ping_id;
		end else if (state == TX_SEND && in_id) begin
			id_sr <= {id_sr[55:0], 8'h00};
		end
	end

	always_comb begin
		tx = '0;
		if (state == TX_SEND) begin
			tx.valid = 1'b1;
			tx.last = last_byte;
			case (cnt)
				16'd0: tx.data = ETHERTYPE_MEAS[15:8];
				16'd1: tx.data = ETHERTYPE_MEAS[7:0];
				16'd2: tx.data = KIND;
				default: tx.data = in_id ? id_sr[63:56] : 8'h00; // Zero padding
			endcase
		end
	end

	assign tx_begin = (state == TX_SEND) && (cnt == '0);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module eth_measurer_tb -f eth_measurer.f || exit 1

out=$(./obj_dir/Veth_measurer_tb)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1
